//--- verilog/sprw_defines.svh
`ifndef SPRW_DEFINES_SVH
`define SPRW_DEFINES_SVH

// word layout, four byte lanes per word
`define SPRW_LANES  4
`define SPRW_BYTE_W 8
`define SPRW_LANE_W 16
`define SPRW_WORD_W 32

// op1 flag bits, arithmetic group only
`define SPRW_OP1_UNS_BIT 4
`define SPRW_OP1_SAT_BIT 3
// op1 bits 4..3 of the logic group
`define SPRW_OP1_LOGIC   2'b11

// op1 function select, bits 2..0
`define SPRW_FN_PASS 3'b000
`define SPRW_FN_ADD  3'b001
`define SPRW_FN_SUB  3'b010
`define SPRW_FN_MOVE 3'b011
`define SPRW_FN_MAX  3'b101
`define SPRW_FN_MIN  3'b110

// logic group select, bits 2..0
`define SPRW_LOG_AND  3'b111
`define SPRW_LOG_OR   3'b000
`define SPRW_LOG_XOR  3'b001
`define SPRW_LOG_NAND 3'b010
`define SPRW_LOG_NOR  3'b011
`define SPRW_LOG_XNOR 3'b100

// op2 reduction codes
`define SPRW_OP2_NONE 3'b000
`define SPRW_OP2_SSUM 3'b001
`define SPRW_OP2_SMAX 3'b010
`define SPRW_OP2_SMIN 3'b011
`define SPRW_OP2_XOR  3'b100
`define SPRW_OP2_USUM 3'b101
`define SPRW_OP2_UMAX 3'b110
`define SPRW_OP2_UMIN 3'b111
`define SPRW_OP2_UNS_BIT 2

// saturation limits
`define SPRW_SMAX 127
`define SPRW_SMIN (-128)
`define SPRW_UMAX 255
`define SPRW_UMIN 0

`endif

//--- verilog/sprw_pkg.sv
`default_nettype none

`include "sprw_defines.svh"

package sprw_pkg;

    typedef logic [`SPRW_BYTE_W-1:0]             byte_t;
    typedef logic [`SPRW_LANE_W-1:0]             lane_t;
    typedef logic [`SPRW_WORD_W-1:0]             word_t;
    // four lane results, lane 0 in the low bits
    typedef logic [`SPRW_LANES*`SPRW_LANE_W-1:0] lanes_t;

    typedef enum logic [3:0] {
        LANE_PASS = 4'd0,
        LANE_ADD  = 4'd1,
        LANE_SUB  = 4'd2,
        LANE_MOVE = 4'd3,
        LANE_MAX  = 4'd4,
        LANE_MIN  = 4'd5,
        LANE_AND  = 4'd6,
        LANE_OR   = 4'd7,
        LANE_XOR  = 4'd8,
        LANE_NAND = 4'd9,
        LANE_NOR  = 4'd10,
        LANE_XNOR = 4'd11
    } lane_fn_t;

    typedef enum logic [2:0] {
        RED_NONE = 3'd0,
        RED_SUM  = 3'd1,
        RED_MAX  = 3'd2,
        RED_MIN  = 3'd3,
        RED_XOR  = 3'd4
    } red_fn_t;

endpackage

`default_nettype wire

//--- verilog/sprw_lane_op_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded operation, decode stage to lane stage
interface sprw_lane_op_if import sprw_pkg::*; ();

    logic     valid;
    word_t    ra;
    word_t    rb;
    lane_fn_t lane_fn;
    logic     sign;
    logic     sat;
    red_fn_t  red_fn;
    logic     red_sign;

    modport src (output valid, ra, rb, lane_fn, sign, sat, red_fn, red_sign);
    modport dst (input  valid, ra, rb, lane_fn, sign, sat, red_fn, red_sign);

endinterface

`default_nettype wire

//--- verilog/sprw_lane_res_if.sv
`timescale 1ns/1ps
`default_nettype none

// lane results and reduction controls, lane stage to reduce stage
interface sprw_lane_res_if import sprw_pkg::*; ();

    logic    valid;
    lanes_t  lanes;
    red_fn_t red_fn;
    logic    red_sign;
    // saturation also clips the reduction sum
    logic    sat;

    modport src (output valid, lanes, red_fn, red_sign, sat);
    modport dst (input  valid, lanes, red_fn, red_sign, sat);

endinterface

`default_nettype wire

//--- verilog/sprw_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprw_defines.svh"

module sprw_decode import sprw_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    input  word_t      ra,
    input  word_t      rb,
    input  logic [4:0] op1,
    input  logic [2:0] op2,
    sprw_lane_op_if.src lop
);

    logic     logic_grp;
    lane_fn_t lane_fn;
    red_fn_t  red_fn;
    logic     sign;
    logic     sat;

    assign logic_grp = (op1[4:3] == `SPRW_OP1_LOGIC);

    always_comb begin
        lane_fn = LANE_PASS;
        if (logic_grp) begin
            case (op1[2:0])
                `SPRW_LOG_AND:  lane_fn = LANE_AND;
                `SPRW_LOG_OR:   lane_fn = LANE_OR;
                `SPRW_LOG_XOR:  lane_fn = LANE_XOR;
                `SPRW_LOG_NAND: lane_fn = LANE_NAND;
                `SPRW_LOG_NOR:  lane_fn = LANE_NOR;
                `SPRW_LOG_XNOR: lane_fn = LANE_XNOR;
                default:        lane_fn = LANE_PASS;
            endcase
        end else begin
            case (op1[2:0])
                `SPRW_FN_ADD:  lane_fn = LANE_ADD;
                `SPRW_FN_SUB:  lane_fn = LANE_SUB;
                `SPRW_FN_MOVE: lane_fn = LANE_MOVE;
                `SPRW_FN_MAX:  lane_fn = LANE_MAX;
                `SPRW_FN_MIN:  lane_fn = LANE_MIN;
                // pass and the unused codes
                default:       lane_fn = LANE_PASS;
            endcase
        end
    end

    // pass and move take their sign from the reduction code
    always_comb begin
        if (logic_grp)
            sign = 1'b0;
        else if (lane_fn == LANE_PASS || lane_fn == LANE_MOVE)
            sign = ~op2[`SPRW_OP2_UNS_BIT] && (op2 != `SPRW_OP2_NONE);
        else
            sign = ~op1[`SPRW_OP1_UNS_BIT];
    end

    assign sat = ~logic_grp & op1[`SPRW_OP1_SAT_BIT];

    always_comb begin
        case (op2)
            `SPRW_OP2_SSUM, `SPRW_OP2_USUM: red_fn = RED_SUM;
            `SPRW_OP2_SMAX, `SPRW_OP2_UMAX: red_fn = RED_MAX;
            `SPRW_OP2_SMIN, `SPRW_OP2_UMIN: red_fn = RED_MIN;
            `SPRW_OP2_XOR:                  red_fn = RED_XOR;
            default:                        red_fn = RED_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            lop.valid <= 1'b0;
        else
            lop.valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        lop.ra       <= ra;
        lop.rb       <= rb;
        lop.lane_fn  <= lane_fn;
        lop.sign     <= sign;
        lop.sat      <= sat;
        lop.red_fn   <= red_fn;
        lop.red_sign <= ~op2[`SPRW_OP2_UNS_BIT];
    end

endmodule

`default_nettype wire

//--- verilog/sprw_lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprw_defines.svh"

module sprw_lane_alu import sprw_pkg::*; (
    input  logic clk,
    input  logic rstn,
    sprw_lane_op_if.dst  lop,
    sprw_lane_res_if.src lres
);

    // two guard bits hold any byte sum or difference
    typedef logic signed [`SPRW_BYTE_W+1:0] wide_t;

    lanes_t lanes_nxt;

    function automatic lane_t ext_byte(input byte_t x, input logic sign);
        return {{(`SPRW_LANE_W-`SPRW_BYTE_W){sign & x[`SPRW_BYTE_W-1]}}, x};
    endfunction

    // full precision value, clipped only when sat is set
    function automatic lane_t clip_lane(input wide_t v, input logic sign, input logic sat);
        logic signed [`SPRW_LANE_W-1:0] w;
        w = {{(`SPRW_LANE_W-`SPRW_BYTE_W-2){v[`SPRW_BYTE_W+1]}}, v};
        if (sat && sign) begin
            if (w > `SPRW_SMAX)
                w = lane_t'(`SPRW_SMAX);
            else if (w < `SPRW_SMIN)
                w = lane_t'(`SPRW_SMIN);
        end else if (sat) begin
            if (w > `SPRW_UMAX)
                w = lane_t'(`SPRW_UMAX);
            else if (w < `SPRW_UMIN)
                w = lane_t'(`SPRW_UMIN);
        end
        return lane_t'(w);
    endfunction

    function automatic lane_t lane_calc(input byte_t a, input byte_t b, input lane_fn_t fn,
                                        input logic sign, input logic sat);
        wide_t ea;
        wide_t eb;
        logic  gt;
        lane_t z;
        ea = {{2{sign & a[`SPRW_BYTE_W-1]}}, a};
        eb = {{2{sign & b[`SPRW_BYTE_W-1]}}, b};
        gt = (ea > eb);
        case (fn)
            LANE_ADD:  z = clip_lane(ea + eb, sign, sat);
            LANE_SUB:  z = clip_lane(ea - eb, sign, sat);
            LANE_MOVE: z = ext_byte(b, sign);
            LANE_MAX:  z = ext_byte(gt ? a : b, sign);
            LANE_MIN:  z = ext_byte(gt ? b : a, sign);
            // logic results are never sign extended
            LANE_AND:  z = ext_byte(a & b, 1'b0);
            LANE_OR:   z = ext_byte(a | b, 1'b0);
            LANE_XOR:  z = ext_byte(a ^ b, 1'b0);
            LANE_NAND: z = ext_byte(~(a & b), 1'b0);
            LANE_NOR:  z = ext_byte(~(a | b), 1'b0);
            LANE_XNOR: z = ext_byte(~(a ^ b), 1'b0);
            default:   z = ext_byte(a, sign);
        endcase
        return z;
    endfunction

    always_comb begin
        for (int i = 0; i < `SPRW_LANES; i++) begin
            lanes_nxt[i*`SPRW_LANE_W +: `SPRW_LANE_W] = lane_calc(
                lop.ra[i*`SPRW_BYTE_W +: `SPRW_BYTE_W],
                lop.rb[i*`SPRW_BYTE_W +: `SPRW_BYTE_W],
                lop.lane_fn, lop.sign, lop.sat);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            lres.valid <= 1'b0;
        else
            lres.valid <= lop.valid;
    end

    // reduction controls follow their lanes
    always_ff @(posedge clk) begin
        lres.lanes    <= lanes_nxt;
        lres.red_fn   <= lop.red_fn;
        lres.red_sign <= lop.red_sign;
        lres.sat      <= lop.sat;
    end

endmodule

`default_nettype wire

//--- verilog/sprw_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprw_defines.svh"

module sprw_reduce import sprw_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    sprw_lane_res_if.dst lres,
    output logic  out_valid,
    output word_t result
);

    localparam int VAL_W = `SPRW_LANE_W + 1;
    // room for four 16-bit lanes, signed or unsigned
    localparam int ACC_W = `SPRW_LANE_W + 3;

    logic signed [VAL_W-1:0] v;
    logic signed [VAL_W-1:0] vmax;
    logic signed [VAL_W-1:0] vmin;
    logic signed [ACC_W-1:0] acc;
    byte_t                   xr;
    word_t                   pk;
    word_t                   sum_w;
    word_t                   red_res;

    always_comb begin
        acc  = '0;
        xr   = '0;
        pk   = '0;
        vmax = '0;
        vmin = '0;
        for (int i = 0; i < `SPRW_LANES; i++) begin
            v = {lres.red_sign & lres.lanes[(i+1)*`SPRW_LANE_W-1],
                 lres.lanes[i*`SPRW_LANE_W +: `SPRW_LANE_W]};
            acc = acc + v;
            if (i == 0 || v > vmax)
                vmax = v;
            if (i == 0 || v < vmin)
                vmin = v;
            xr = xr ^ lres.lanes[i*`SPRW_LANE_W +: `SPRW_BYTE_W];
            pk[i*`SPRW_BYTE_W +: `SPRW_BYTE_W] = lres.lanes[i*`SPRW_LANE_W +: `SPRW_BYTE_W];
        end
    end

    // sum clips to byte limits, not lane limits
    always_comb begin
        sum_w = {{(`SPRW_WORD_W-ACC_W){acc[ACC_W-1]}}, acc};
        if (lres.sat && lres.red_sign) begin
            if (acc > `SPRW_SMAX)
                sum_w = word_t'(`SPRW_SMAX);
            else if (acc < `SPRW_SMIN)
                sum_w = word_t'(`SPRW_SMIN);
        end else if (lres.sat) begin
            if (acc > `SPRW_UMAX)
                sum_w = word_t'(`SPRW_UMAX);
            else if (acc < `SPRW_UMIN)
                sum_w = word_t'(`SPRW_UMIN);
        end
    end

    always_comb begin
        case (lres.red_fn)
            RED_SUM: red_res = sum_w;
            RED_MAX: red_res = {{(`SPRW_WORD_W-VAL_W){vmax[VAL_W-1]}}, vmax};
            RED_MIN: red_res = {{(`SPRW_WORD_W-VAL_W){vmin[VAL_W-1]}}, vmin};
            RED_XOR: red_res = {{(`SPRW_WORD_W-`SPRW_BYTE_W){1'b0}}, xr};
            default: red_res = pk;
        endcase
    end

    // result holds between operations
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= lres.valid;
            if (lres.valid)
                result <= red_res;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sprw_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_top import sprw_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    input  word_t      ra,
    input  word_t      rb,
    input  logic [4:0] op1,
    input  logic [2:0] op2,
    output logic       out_valid,
    output word_t      result
);

    sprw_lane_op_if  lop ();
    sprw_lane_res_if lres ();

    // stage 1, operand and opcode register
    sprw_decode sprw_decode_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .ra       (ra),
        .rb       (rb),
        .op1      (op1),
        .op2      (op2),
        .lop      (lop.src)
    );

    // stage 2, per lane execution
    sprw_lane_alu sprw_lane_alu_i (
        .clk  (clk),
        .rstn (rstn),
        .lop  (lop.dst),
        .lres (lres.src)
    );

    // stage 3, horizontal reduction
    sprw_reduce sprw_reduce_i (
        .clk       (clk),
        .rstn      (rstn),
        .lres      (lres.dst),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- test/sprw_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// 10 ns clock, reset low over the first two rising edges
module sprw_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk  = 1'b0;
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

//--- test/sprw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_tb import sprw_pkg::*; ();

    logic       clk;
    logic       rstn;
    logic       in_valid;
    word_t      ra;
    word_t      rb;
    logic [4:0] op1;
    logic [2:0] op2;
    logic       out_valid;
    word_t      result;

    // expected results in issue order, with name and sampling edge
    word_t exp_q [$];
    string name_q [$];
    int    edge_q [$];
    word_t exp_w;
    string exp_name;
    int    exp_edge;

    int cyc = 0;
    int issued = 0;
    int received = 0;
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;

    logic [2:0] arith_sel [6] = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b101, 3'b110};
    logic [2:0] logic_sel [6] = '{3'b111, 3'b000, 3'b001, 3'b010, 3'b011, 3'b100};
    // operand pairs at the signed and unsigned byte limits
    word_t lim_a [3] = '{32'h7f7f8080, 32'hff00ff00, 32'h807f00ff};
    word_t lim_b [3] = '{32'h0180017f, 32'h01ff00ff, 32'h80807f01};

    sprw_clk_gen sprw_clk_gen_i (.clk(clk), .rstn(rstn));

    sprw_top sprw_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .ra        (ra),
        .rb        (rb),
        .op1       (op1),
        .op2       (op2),
        .out_valid (out_valid),
        .result    (result)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int limit_to_byte(input int v, input logic sign);
        if (sign)
            return (v > 127) ? 127 : ((v < -128) ? -128 : v);
        return (v > 255) ? 255 : ((v < 0) ? 0 : v);
    endfunction

    function automatic logic [15:0] lane_value(input logic [7:0] a, input logic [7:0] b,
                                               input logic [4:0] o1, input logic [2:0] o2);
        logic [2:0] sel;
        logic [7:0] lb;
        logic       sign;
        int         av;
        int         bv;
        int         r;
        sel = o1[2:0];
        // logic group results are zero extended bytes
        if (o1[4:3] == 2'b11) begin
            case (sel)
                3'b111:  lb = a & b;
                3'b000:  lb = a | b;
                3'b001:  lb = a ^ b;
                3'b010:  lb = ~(a & b);
                3'b011:  lb = ~(a | b);
                default: lb = ~(a ^ b);
            endcase
            return {8'h00, lb};
        end
        if (sel == 3'b000 || sel == 3'b011)
            sign = (o2[2] == 1'b0) && (o2 != 3'b000);
        else
            sign = ~o1[4];
        if (sign) begin
            av = $signed(a);
            bv = $signed(b);
        end else begin
            av = a;
            bv = b;
        end
        case (sel)
            3'b001:  r = av + bv;
            3'b010:  r = av - bv;
            3'b011:  r = bv;
            3'b101:  r = (av > bv) ? av : bv;
            3'b110:  r = (av < bv) ? av : bv;
            default: r = av;
        endcase
        if (o1[3] && (sel == 3'b001 || sel == 3'b010))
            r = limit_to_byte(r, sign);
        return r[15:0];
    endfunction

    // reference model of the whole pipeline
    function automatic word_t expected_word(input word_t a, input word_t b,
                                            input logic [4:0] o1, input logic [2:0] o2);
        logic [15:0] lanes [4];
        int          v [4];
        logic        rsign;
        int          acc;
        int          mx;
        int          mn;
        logic [7:0]  xr;
        word_t       pk;
        rsign = ~o2[2];
        acc = 0;
        mx = 0;
        mn = 0;
        xr = 8'h00;
        for (int i = 0; i < 4; i++) begin
            lanes[i] = lane_value(a[8*i +: 8], b[8*i +: 8], o1, o2);
            if (rsign)
                v[i] = $signed(lanes[i]);
            else
                v[i] = lanes[i];
            acc += v[i];
            if (i == 0 || v[i] > mx)
                mx = v[i];
            if (i == 0 || v[i] < mn)
                mn = v[i];
            xr ^= lanes[i][7:0];
            pk[8*i +: 8] = lanes[i][7:0];
        end
        case (o2)
            3'b001, 3'b101: begin
                if (o1[4:3] != 2'b11 && o1[3])
                    acc = limit_to_byte(acc, rsign);
                return acc;
            end
            3'b010, 3'b110: return mx;
            3'b011, 3'b111: return mn;
            3'b100:         return {24'h0, xr};
            default:        return pk;
        endcase
    endfunction

    function automatic logic [4:0] random_op1();
        logic [1:0] flags;
        if ($urandom_range(0, 3) == 0)
            return {2'b11, logic_sel[$urandom_range(0, 5)]};
        // unsigned with saturation falls in the logic group
        flags = 2'($urandom_range(0, 2));
        return {flags, arith_sel[$urandom_range(0, 5)]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            value_errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic send_op(input word_t a, input word_t b, input logic [4:0] o1,
                           input logic [2:0] o2, input string name);
        in_valid = 1'b1;
        ra = a;
        rb = b;
        op1 = o1;
        op2 = o2;
        exp_q.push_back(expected_word(a, b, o1, o2));
        name_q.push_back(name);
        edge_q.push_back(cyc + 1);
        issued++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_reset();
        int t;
        t = 0;
        while (rstn !== 1'b1 && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (rstn !== 1'b1) begin
            other_errors++;
            $display("reset was never released");
        end
        #1;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("timed out with %0d results still outstanding", exp_q.size());
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstn && out_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("out_valid was high with no operation outstanding");
            end else begin
                exp_w = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_edge = edge_q.pop_front();
                received++;
                check_value(exp_name, exp_w, result);
                check_value({exp_name, "_latency"}, exp_edge + 2, cyc);
            end
        end
    end

    initial begin
        in_valid = 1'b0;
        ra = '0;
        rb = '0;
        op1 = '0;
        op2 = '0;
        void'($urandom(9035));
        wait_reset();

        // quiet outputs until the first operation
        repeat (3) begin
            @(negedge clk);
            check_value("reset_out_valid", 32'd0, {31'd0, out_valid});
            check_value("reset_result", 32'd0, result);
        end
        idle(1);

        for (int f = 1; f <= 2; f++)
            for (int fl = 0; fl < 3; fl++)
                for (int p = 0; p < 3; p++)
                    send_op(lim_a[p], lim_b[p], {2'(fl), 3'(f)}, 3'b000, "arith_limits");
        repeat (30)
            send_op($urandom, $urandom, {2'($urandom_range(0, 2)), 3'($urandom_range(1, 2))},
                    3'b000, "arith_random");
        idle(2);

        // max, min, pass, move, then the logic group
        foreach (arith_sel[s])
            if (arith_sel[s] != 3'b001 && arith_sel[s] != 3'b010)
                repeat (6)
                    send_op($urandom, $urandom, {2'($urandom_range(0, 2)), arith_sel[s]},
                            3'b000, "lane_fn");
        foreach (logic_sel[s])
            repeat (5)
                send_op($urandom, $urandom, {2'b11, logic_sel[s]}, 3'b000, "lane_logic");
        idle(2);

        send_op(32'h7f7f7f7f, 32'h7f7f7f7f, 5'b01001, 3'b001, "reduce_sat_sum");
        send_op(32'h80808080, 32'h80808080, 5'b01001, 3'b001, "reduce_sat_sum");
        repeat (80)
            send_op($urandom, $urandom, random_op1(), 3'($urandom_range(1, 7)), "reduce");
        idle(3);

        // strobes on consecutive cycles with random gaps
        repeat (60) begin
            send_op($urandom, $urandom, random_op1(), 3'($urandom_range(0, 7)), "back_to_back");
            if ($urandom_range(0, 3) == 0)
                idle($urandom_range(1, 3));
        end

        wait_drain();
        idle(4);
        check_value("out_valid_count", issued, received);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/sprw_pkg.sv
verilog/sprw_lane_op_if.sv
verilog/sprw_lane_res_if.sv
verilog/sprw_decode.sv
verilog/sprw_lane_alu.sv
verilog/sprw_reduce.sv
verilog/sprw_top.sv
test/sprw_clk_gen.sv
test/sprw_tb.sv
